// ==== Makefile ====
SIM       ?= verilator
SIM_FLAGS ?= --binary --timing --assert -j 0
TOP       ?= tb_vertical_filter
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT := Finished with no errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BINARY): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# the log decides pass or fail
run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
source/vfilter_pkg.sv
source/line_delay.sv
source/row_window_buffer.sv
source/column_adder.sv
source/vertical_filter_top.sv
verification/tb_vertical_filter.sv

// ==== source/column_adder.sv ====
`default_nettype none
`timescale 1ns/1ps

module column_adder (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire vfilter_pkg::column_t window_i,
    output vfilter_pkg::sum_t       column_sum_o,
    output logic                    done_o
);

    localparam int LOWER_ROWS = vfilter_pkg::LOWER_ROWS;
    localparam int ROWS       = vfilter_pkg::WINDOW_ROWS;

    vfilter_pkg::partial_sum_t lower_sum;
    vfilter_pkg::partial_sum_t upper_sum;

    vfilter_pkg::partial_sum_t lower_sum_q;
    vfilter_pkg::partial_sum_t upper_sum_q;
    logic                      done_q;

    // adds rows first..last of a column, seven full-scale rows still fit
    function automatic vfilter_pkg::partial_sum_t sum_rows(
        input vfilter_pkg::column_t col,
        input int                   first,
        input int                   last
    );
        vfilter_pkg::partial_sum_t acc;
        acc = '0;
        for (int k = first; k <= last; k++) begin
            acc = acc + vfilter_pkg::partial_sum_t'(col.rows[k]);
        end
        return acc;
    endfunction

    // newer rows go to the lower half, older rows to the upper half
    always_comb begin
        lower_sum = sum_rows(window_i, 0, LOWER_ROWS - 1);
        upper_sum = sum_rows(window_i, LOWER_ROWS, ROWS - 1);
    end

    // stage 1 holds the two partial sums
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lower_sum_q <= '0;
            upper_sum_q <= '0;
            done_q      <= 1'b0;
        end else begin
            lower_sum_q <= lower_sum;
            upper_sum_q <= upper_sum;
            done_q      <= window_i.done;
        end
    end

    // stage 2 holds the column total
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            column_sum_o <= '0;
            done_o       <= 1'b0;
        end else begin
            column_sum_o <= vfilter_pkg::sum_t'(lower_sum_q) +
                            vfilter_pkg::sum_t'(upper_sum_q);
            done_o       <= done_q;
        end
    end

    a_sum_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        column_sum_o <= vfilter_pkg::sum_t'(vfilter_pkg::MAX_COLUMN_SUM)
    ) else $error("column sum above maximum, got %0h", column_sum_o);

endmodule

`default_nettype wire

// ==== source/line_delay.sv ====
`default_nettype none
`timescale 1ns/1ps

module line_delay #(
    parameter int DELAY = vfilter_pkg::LINE_WIDTH
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire vfilter_pkg::pixel_t data_i,
    input  wire                  done_i,
    output vfilter_pkg::pixel_t  data_o,
    output logic                 done_o
);

    // pixel and its frame marker shift side by side so they stay aligned
    vfilter_pkg::pixel_t pixel_sr [DELAY];
    logic                done_sr  [DELAY];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DELAY; i++) begin
                pixel_sr[i] <= '0;
                done_sr[i]  <= 1'b0;
            end
        end else begin
            pixel_sr[0] <= data_i;
            done_sr[0]  <= done_i;
            for (int i = 1; i < DELAY; i++) begin
                pixel_sr[i] <= pixel_sr[i-1];
                done_sr[i]  <= done_sr[i-1];
            end
        end
    end

    // the last stage holds what entered DELAY cycles ago
    assign data_o = pixel_sr[DELAY-1];
    assign done_o = done_sr[DELAY-1];

    // a stuck X on the marker would poison every later stage of the chain
    a_done_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(done_o)
    ) else $error("line_delay done_o is unknown");

endmodule

`default_nettype wire

// ==== source/row_window_buffer.sv ====
`default_nettype none
`timescale 1ns/1ps

module row_window_buffer (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire vfilter_pkg::pixel_t pixel_i,
    input  wire                    done_i,
    output vfilter_pkg::column_t   window_o
);

    localparam int NUM_DELAYS = vfilter_pkg::NUM_DELAYS;

    vfilter_pkg::flush_count_t flush_count;
    logic                      flush_active;

    // chain taps, index 0 is the live input and index k is k lines old
    vfilter_pkg::pixel_t chain_data [NUM_DELAYS+1];
    logic                chain_done [NUM_DELAYS+1];

    // done stretcher
    // a done pulse keeps the chain input marked for one more line so the
    // last rows of the frame are pushed out behind it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flush_count  <= '0;
            flush_active <= 1'b0;
        end else if (done_i) begin
            // a new frame end restarts the flush
            flush_count  <= '0;
            flush_active <= 1'b1;
        end else if (flush_active &&
                     flush_count < vfilter_pkg::flush_count_t'(vfilter_pkg::LINE_WIDTH)) begin
            flush_count  <= flush_count + vfilter_pkg::flush_count_t'(1);
            flush_active <= 1'b1;
        end else begin
            flush_count  <= '0;
            flush_active <= 1'b0;
        end
    end

    assign chain_data[0] = pixel_i;
    assign chain_done[0] = done_i | flush_active;

    for (genvar g = 0; g < NUM_DELAYS; g++) begin : gen_line_delays
        line_delay #(
            .DELAY  (vfilter_pkg::LINE_WIDTH)
        ) i_line_delay (
            .clk    (clk),
            .rst_n  (rst_n),
            .data_i (chain_data[g]),
            .done_i (chain_done[g]),
            .data_o (chain_data[g+1]),
            .done_o (chain_done[g+1])
        );
    end

    // row 0 passes straight through from the input
    always_comb begin
        for (int k = 0; k <= NUM_DELAYS; k++) begin
            window_o.rows[k] = chain_data[k];
        end
        window_o.done = chain_done[NUM_DELAYS];
    end

    a_flush_count_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush_count <= vfilter_pkg::flush_count_t'(vfilter_pkg::LINE_WIDTH)
    ) else $error("flush counter passed the line width, got %0d", flush_count);

    // the stretched marker must reach the end of the chain twelve lines later
    a_done_reaches_window: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(chain_done[0]) |-> ##(NUM_DELAYS * vfilter_pkg::LINE_WIDTH) window_o.done
    ) else $error("frame marker did not arrive at the window");

endmodule

`default_nettype wire

// ==== source/vertical_filter_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module vertical_filter_top (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire vfilter_pkg::pixel_t pixel_i,
    input  wire                    done_i,
    output vfilter_pkg::sum_t      column_sum_o,
    output logic                   done_o
);

    // thirteen-row column between the line buffers and the adder tree
    vfilter_pkg::column_t window;

    row_window_buffer i_row_window_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .pixel_i  (pixel_i),
        .done_i   (done_i),
        .window_o (window)
    );

    // two cycles of latency from window to sum
    column_adder i_column_adder (
        .clk          (clk),
        .rst_n        (rst_n),
        .window_i     (window),
        .column_sum_o (column_sum_o),
        .done_o       (done_o)
    );

endmodule

`default_nettype wire

// ==== source/vfilter_pkg.sv ====
`default_nettype none

package vfilter_pkg;

    // image geometry
    localparam int LINE_WIDTH  = 17;
    localparam int WINDOW_ROWS = 13;

    // one line delay sits between each pair of neighbouring rows
    localparam int NUM_DELAYS = WINDOW_ROWS - 1;

    // the adder tree splits the column after this many rows
    localparam int LOWER_ROWS = 7;

    // largest column sum, 13 rows of full white
    localparam int MAX_COLUMN_SUM = WINDOW_ROWS * 255;

    // one greyscale pixel
    typedef logic [7:0] pixel_t;

    // sum of a whole column, wide enough for MAX_COLUMN_SUM
    typedef logic [11:0] sum_t;

    // first stage sums of at most seven rows
    typedef logic [10:0] partial_sum_t;

    // done stretcher counter
    typedef logic [9:0] flush_count_t;

    // thirteen vertically aligned pixels with the frame marker
    // row 0 is the live input and row 12 the oldest line
    typedef struct packed {
        logic                          done;
        pixel_t [WINDOW_ROWS-1:0]      rows;
    } column_t;

endpackage

`default_nettype wire

// ==== verification/tb_vertical_filter.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_vertical_filter;

    localparam int LINE_WIDTH    = vfilter_pkg::LINE_WIDTH;
    localparam int WINDOW_ROWS   = vfilter_pkg::WINDOW_ROWS;
    localparam int CHAIN_DEPTH   = vfilter_pkg::NUM_DELAYS * LINE_WIDTH;
    localparam int ADDER_LATENCY = 2;
    localparam int DONE_FIRST    = CHAIN_DEPTH + ADDER_LATENCY;
    localparam int DONE_LAST     = DONE_FIRST + LINE_WIDTH + 1;

    localparam int HIST_DEPTH        = 2048;
    localparam int TIMEOUT_CYCLES    = 2000;
    localparam int IDLE_CYCLES       = 20;
    localparam int RANDOM_CYCLES     = 300;
    localparam int FULL_SCALE_CYCLES = 15 * LINE_WIDTH;
    localparam int FLUSH_CYCLES      = DONE_LAST + 16;
    localparam int RESTART_GAP       = 10;

    logic                 clk = 1'b0;
    logic                 rst_n;
    vfilter_pkg::pixel_t  pixel_i;
    logic                 done_i;
    vfilter_pkg::sum_t    column_sum_o;
    logic                 done_o;

    // everything driven since reset, indexed by the rising edge that samples it
    vfilter_pkg::pixel_t  pixel_hist [HIST_DEPTH];
    bit                   done_hist  [HIST_DEPTH];

    int                   cycle           = 0;
    int                   last_live_cycle = -1;
    int                   run_cycles      = 0;
    int                   seed            = 87;

    // model outputs for the next rising edge, updated on the falling edge
    vfilter_pkg::sum_t    expected_sum  = '0;
    logic                 expected_done = 1'b0;
    logic                 quiet_window  = 1'b0;
    logic                 flushed       = 1'b0;
    logic                 full_scale    = 1'b0;

    logic                 saw_full_scale = 1'b0;
    logic                 saw_done       = 1'b0;

    always #2 clk = ~clk;

    vertical_filter_top i_vertical_filter_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .pixel_i      (pixel_i),
        .done_i       (done_i),
        .column_sum_o (column_sum_o),
        .done_o       (done_o)
    );

    task automatic stop_on_mismatch(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        $display("[FAIL] %s expected %0h got %0h", name, expected, actual);
        $display("Finished with errors");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic stop_with_reason(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "%s", reason);
    endtask

    // sum of the thirteen pixels one line apart that reach the output at edge e
    function automatic vfilter_pkg::sum_t reference_column_sum(input int e);
        int total;
        int idx;
        total = 0;
        for (int k = 0; k < WINDOW_ROWS; k++) begin
            idx = e - ADDER_LATENCY - k * LINE_WIDTH;
            if (idx >= 0) begin
                total = total + int'(pixel_hist[idx]);
            end
        end
        return vfilter_pkg::sum_t'(total);
    endfunction

    // a frame end at s keeps done_o high on edges s+206 through s+224
    function automatic logic reference_done(input int e);
        logic hit;
        hit = 1'b0;
        for (int s = e - DONE_LAST; s <= e - DONE_FIRST; s++) begin
            if (s >= 0 && done_hist[s]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic record_inputs(input vfilter_pkg::pixel_t pixel, input logic done);
        pixel_i           = pixel;
        done_i            = done;
        pixel_hist[cycle] = pixel;
        done_hist[cycle]  = done;
        if (pixel != '0) begin
            last_live_cycle = cycle;
        end
        expected_sum  = reference_column_sum(cycle);
        expected_done = reference_done(cycle);
        quiet_window  = (cycle < IDLE_CYCLES + ADDER_LATENCY);
        flushed       = (cycle > last_live_cycle + DONE_FIRST);
        full_scale    = (expected_sum == vfilter_pkg::sum_t'(vfilter_pkg::MAX_COLUMN_SUM));
        cycle         = cycle + 1;
    endtask

    task automatic drive_cycle(input vfilter_pkg::pixel_t pixel, input logic done);
        @(negedge clk);
        record_inputs(pixel, done);
    endtask

    // the falling edge that releases reset also sets up edge 0
    task automatic release_reset();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        record_inputs('0, 1'b0);
    endtask

    task automatic drive_random_pixels(input int count);
        logic [31:0] rand_word;
        for (int i = 0; i < count; i++) begin
            rand_word = $random(seed);
            drive_cycle(rand_word[7:0], 1'b0);
        end
    endtask

    task automatic drive_constant_pixels(input vfilter_pkg::pixel_t value, input int count);
        for (int i = 0; i < count; i++) begin
            drive_cycle(value, 1'b0);
        end
    endtask

    a_quiet_sum: assert property (
        @(posedge clk) disable iff (!rst_n)
        quiet_window |-> column_sum_o == '0
    ) else stop_on_mismatch("column_sum_o", 32'h0, 32'($sampled(column_sum_o)));

    a_quiet_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        quiet_window |-> !done_o
    ) else stop_on_mismatch("done_o", 32'h0, 32'($sampled(done_o)));

    a_column_sum: assert property (
        @(posedge clk) disable iff (!rst_n)
        column_sum_o == expected_sum
    ) else stop_on_mismatch("column_sum_o", 32'($sampled(expected_sum)),
                            32'($sampled(column_sum_o)));

    a_full_scale_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        full_scale |-> column_sum_o == vfilter_pkg::sum_t'(vfilter_pkg::MAX_COLUMN_SUM)
    ) else stop_on_mismatch("column_sum_o", 32'(vfilter_pkg::MAX_COLUMN_SUM),
                            32'($sampled(column_sum_o)));

    a_flushed_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        flushed |-> column_sum_o == '0
    ) else stop_on_mismatch("column_sum_o", 32'h0, 32'($sampled(column_sum_o)));

    a_done_window: assert property (
        @(posedge clk) disable iff (!rst_n)
        done_o == expected_done
    ) else stop_on_mismatch("done_o", 32'($sampled(expected_done)), 32'($sampled(done_o)));

    always @(posedge clk) begin
        if (rst_n && column_sum_o == vfilter_pkg::sum_t'(vfilter_pkg::MAX_COLUMN_SUM)) begin
            saw_full_scale <= 1'b1;
        end
        if (rst_n && done_o) begin
            saw_done <= 1'b1;
        end
    end

    always @(posedge clk) begin
        run_cycles <= run_cycles + 1;
        if (run_cycles >= TIMEOUT_CYCLES) begin
            stop_with_reason("timeout, the stimulus did not finish in time");
        end
    end

    initial begin
        rst_n   = 1'b0;
        pixel_i = '0;
        done_i  = 1'b0;
        for (int i = 0; i < HIST_DEPTH; i++) begin
            pixel_hist[i] = '0;
            done_hist[i]  = 1'b0;
        end

        release_reset();
        drive_constant_pixels(8'h00, IDLE_CYCLES - 1);

        drive_random_pixels(RANDOM_CYCLES);

        // full white for more than a window of lines
        drive_constant_pixels(8'hff, FULL_SCALE_CYCLES);

        // single frame end, then black until the chain is empty
        drive_cycle('0, 1'b1);
        drive_constant_pixels(8'h00, FLUSH_CYCLES);

        // second frame end lands while the stretcher is still running
        drive_random_pixels(40);
        drive_cycle('0, 1'b1);
        drive_random_pixels(RESTART_GAP - 1);
        drive_cycle('0, 1'b1);
        drive_constant_pixels(8'h00, FLUSH_CYCLES);

        // the last driven cycle still has a rising edge to be checked on
        @(negedge clk);

        if (!saw_full_scale || !saw_done) begin
            $display("the full scale sum or the delayed frame end never showed up");
            $display("Finished with errors");
            $fatal(1, "expected output events missing");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire
